// ==== vlog.f ====
src/io_pkg.sv
src/audio_pkg.sv
src/spi_download.sv
src/cart_ram.sv
src/sample_player.sv
src/sigma_delta_dac.sv
src/vc4000_audio_top.sv
sim/tb_vc4000_audio.sv

// ==== Makefile ====
# Verilator simulation of the VC4000 download and audio path.

VERILATOR ?= verilator
TOP       ?= tb_vc4000_audio
SEED      ?= 96
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/download_patterns.txt ====
// record: index, byte count, image bytes, number of sample windows to check
// an index of ff ends the list
// cartridge image with both extremes, checked past its end
00
05
00 01 80 ff 3c
0c
// other index, the first image keeps playing from byte 0
01
03
aa bb cc
08
// shorter cartridge image, wraps after two bytes
00
02
7f 10
05
// other index again, the short image stays
02
01
55
04
// four bytes, replaces the short image
00
04
01 fe 40 c0
06
ff

// ==== sim/tb_vc4000_audio.sv ====
`default_nettype none

module tb_vc4000_audio #(
	parameter int SEED = 96
);

	localparam int CLK_T     = 4;
	localparam int SCK_HALF  = 5;
	localparam int BIT_T     = 2 * SCK_HALF * CLK_T;
	localparam int FRAME_CYC = 32;
	localparam int PAT_DEPTH = 1024;

	logic clk_sys = 1'b0;
	logic arst_n;
	logic SPI_SCK;
	logic SPI_SS2;
	logic SPI_DI;
	wire  LED;
	wire  AUDIO_L;
	wire  AUDIO_R;

	logic [7:0] pats  [0:PAT_DEPTH-1];
	logic [7:0] image [0:255];
	int         img_len = 0;

	vc4000_audio_top UUT (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.SPI_SCK (SPI_SCK),
		.SPI_SS2 (SPI_SS2),
		.SPI_DI  (SPI_DI),
		.LED     (LED),
		.AUDIO_L (AUDIO_L),
		.AUDIO_R (AUDIO_R)
	);

	always #(CLK_T / 2) clk_sys = ~clk_sys;

	task automatic check_equal(input int expected, input int actual, input string what);
		if (expected != actual) begin
			$display("FAIL %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// msb first, sck low then high for SCK_HALF cycles each.
	task automatic shift_byte(input logic [7:0] value);
		for (int i = 7; i >= 0; i--) begin
			SPI_SCK = 1'b0;
			SPI_DI  = value[i];
			repeat (SCK_HALF) @(negedge clk_sys);
			SPI_SCK = 1'b1;
			repeat (SCK_HALF) @(negedge clk_sys);
		end
		SPI_SCK = 1'b0;
	endtask

	task automatic open_frame;
		int gap;
		gap = int'($urandom % 16);
		repeat (gap + 1) @(negedge clk_sys);
		SPI_SS2 = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic close_frame;
		repeat (SCK_HALF) @(negedge clk_sys);
		SPI_SS2 = 1'b1;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic send_command(input logic [7:0] cmd, input logic [7:0] arg);
		open_frame();
		shift_byte(cmd);
		shift_byte(arg);
		close_frame();
	endtask

	task automatic send_data(input int first, input int count);
		open_frame();
		shift_byte(io_pkg::UIO_FILE_TX_DAT);
		for (int i = 0; i < count; i++)
			shift_byte(pats[first + i]);
		close_frame();
	endtask

	// returns on the falling edge right after edge D.
	task automatic wait_download_end;
		@(negedge clk_sys);
		while (LED !== 1'b1)
			@(negedge clk_sys);
	endtask

	// window k spans edges D+DAC_LAT+256k up to D+DAC_LAT+256k+255.
	task automatic check_windows(input int count);
		int ones;
		int expected;
		repeat (audio_pkg::DAC_LAT - 1) @(negedge clk_sys);
		for (int k = 0; k < count; k++) begin
			ones = 0;
			repeat (audio_pkg::SAMPLE_DIV) begin
				@(negedge clk_sys);
				ones += int'(AUDIO_L);
			end
			expected = (img_len == 0) ? 0 : int'(image[k % img_len]);
			check_equal(expected, ones, $sformatf("ones in window %0d", k));
		end
	endtask

	always @(negedge clk_sys) begin
		if (arst_n === 1'b1)
			check_equal(int'(AUDIO_L), int'(AUDIO_R), "AUDIO_R against AUDIO_L");
	end

	initial begin
		int     p;
		int     cnt;
		int     nsmp;
		int     records;
		int     spi_bytes;
		int     samples;
		longint limit;
		arst_n  = 1'b0;
		SPI_SCK = 1'b0;
		SPI_SS2 = 1'b1;
		SPI_DI  = 1'b0;
		void'($urandom(SEED));
		$readmemh("sim/download_patterns.txt", pats);

		// each record costs four frames: index, start, data, end.
		p         = 0;
		records   = 0;
		spi_bytes = 0;
		samples   = 0;
		while (p < PAT_DEPTH - 2 && pats[p] != 8'hff) begin
			cnt       = int'(pats[p + 1]);
			records   += 1;
			spi_bytes += cnt + 7;
			samples   += int'(pats[p + 2 + cnt]);
			p         += cnt + 3;
		end
		if (p >= PAT_DEPTH - 2 || records == 0) begin
			$display("pattern file holds no complete list of downloads");
			$display("TEST FAILED");
			$fatal(1, "bad pattern file");
		end

		limit = 2 * (longint'(spi_bytes) * 8 * BIT_T +
			(longint'(records) * 4 * FRAME_CYC + 300 +
			longint'(samples + records) * audio_pkg::SAMPLE_DIV) * CLK_T);
		fork
			begin
				#(limit);
				$display("timeout: the run did not finish within %0d time units", limit);
				$display("TEST FAILED");
				$fatal(1, "watchdog expired");
			end
		join_none

		repeat (8) @(negedge clk_sys);
		arst_n = 1'b1;
		repeat (audio_pkg::SAMPLE_DIV) begin
			@(negedge clk_sys);
			check_equal(1, int'(LED), "LED after reset");
			check_equal(0, int'(AUDIO_L), "AUDIO_L after reset");
		end

		p = 0;
		while (pats[p] != 8'hff) begin
			cnt  = int'(pats[p + 1]);
			nsmp = int'(pats[p + 2 + cnt]);
			send_command(io_pkg::UIO_FILE_INDEX, pats[p]);
			send_command(io_pkg::UIO_FILE_TX, 8'h01);
			check_equal(0, int'(LED), "LED after start command");
			send_data(p + 2, cnt);
			check_equal(0, int'(LED), "LED before end command");

			// only the cartridge index replaces the image.
			if (pats[p] == io_pkg::BIN_INDEX) begin
				for (int i = 0; i < cnt; i++)
					image[i] = pats[p + 2 + i];
				img_len = cnt;
			end

			fork
				send_command(io_pkg::UIO_FILE_TX, 8'h00);
				begin
					wait_download_end();
					check_windows(nsmp);
				end
			join
			p += cnt + 3;
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/vc4000_audio_top.sv ====
`default_nettype none

module vc4000_audio_top (
	input  wire clk_sys,
	input  wire arst_n,
	input  wire SPI_SCK,
	input  wire SPI_SS2,
	input  wire SPI_DI,
	output wire LED,
	output wire AUDIO_L,
	output wire AUDIO_R
);

	wire                            ioctl_download;
	wire [7:0]                      ioctl_index;
	wire                            ioctl_wr;
	wire [io_pkg::IOCTL_AW-1:0]     ioctl_addr;
	wire [7:0]                      ioctl_dout;
	wire [audio_pkg::CART_AW-1:0]   rom_addr;
	wire [audio_pkg::SAMPLE_W-1:0]  rom_do;
	wire [audio_pkg::CART_AW:0]     rom_len;
	wire [audio_pkg::SAMPLE_W-1:0]  sample;

	// led off while a download runs.
	assign LED     = ~ioctl_download;
	assign AUDIO_R = AUDIO_L;

	spi_download spi_download (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.SPI_DI         (SPI_DI),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	cart_ram cart_ram (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_addr       (rom_addr),
		.rom_do         (rom_do),
		.rom_len        (rom_len)
	);

	sample_player sample_player (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.rom_len        (rom_len),
		.rom_do         (rom_do),
		.rom_addr       (rom_addr),
		.sample         (sample)
	);

	sigma_delta_dac dac (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.dac_i   (sample),
		.dac_o   (AUDIO_L)
	);

endmodule

`default_nettype wire

// ==== src/sigma_delta_dac.sv ====
`default_nettype none

module sigma_delta_dac (
	input  wire                           clk_sys,
	input  wire                           arst_n,
	input  wire [audio_pkg::SAMPLE_W-1:0] dac_i,
	output wire                           dac_o
);

	// one bit wider than the sample, top bit is the carry.
	logic [audio_pkg::SAMPLE_W:0] acc;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[audio_pkg::SAMPLE_W-1:0]} + {1'b0, dac_i};
	end

	// carry density tracks dac_i / 256.
	assign dac_o = acc[audio_pkg::SAMPLE_W];

endmodule

`default_nettype wire

// ==== src/sample_player.sv ====
`default_nettype none

module sample_player (
	input  wire                            clk_sys,
	input  wire                            arst_n,
	input  wire                            ioctl_download,
	input  wire  [audio_pkg::CART_AW:0]    rom_len,
	input  wire  [audio_pkg::SAMPLE_W-1:0] rom_do,
	output logic [audio_pkg::CART_AW-1:0]  rom_addr,
	output logic [audio_pkg::SAMPLE_W-1:0] sample
);

	typedef enum logic [1:0] {
		IDLE,
		PRIME,
		PLAY
	} state_t;

	state_t                       state;
	logic [audio_pkg::DIV_W-1:0]  div;
	logic [audio_pkg::CART_AW:0]  addr_inc;
	logic                         wrap;

	assign addr_inc = {1'b0, rom_addr} + 1'b1;
	assign wrap     = addr_inc == rom_len;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			div      <= '0;
			rom_addr <= '0;
			sample   <= '0;
		end else if (ioctl_download) begin
			state    <= IDLE;
			div      <= '0;
			rom_addr <= '0;
			sample   <= '0;
		end else begin
			case (state)
				IDLE: begin
					rom_addr <= '0;
					sample   <= '0;
					div      <= '0;
					if (rom_len != '0)
						state <= PRIME;
				end
				// ram output for address 0 lands this cycle.
				PRIME: begin
					div   <= audio_pkg::DIV_LAST;
					state <= PLAY;
				end
				PLAY: begin
					if (div == audio_pkg::DIV_LAST) begin
						div      <= '0;
						sample   <= rom_do;
						rom_addr <= wrap ? '0 : addr_inc[audio_pkg::CART_AW-1:0];
					end else begin
						div <= div + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	addr_below_len: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		state == PLAY |-> {1'b0, rom_addr} < rom_len
	);

endmodule

`default_nettype wire

// ==== src/cart_ram.sv ====
`default_nettype none

module cart_ram (
	input  wire                            clk_sys,
	input  wire                            arst_n,
	input  wire                            ioctl_download,
	input  wire  [7:0]                     ioctl_index,
	input  wire                            ioctl_wr,
	input  wire  [io_pkg::IOCTL_AW-1:0]    ioctl_addr,
	input  wire  [7:0]                     ioctl_dout,
	input  wire  [audio_pkg::CART_AW-1:0]  rom_addr,
	output logic [audio_pkg::SAMPLE_W-1:0] rom_do,
	output logic [audio_pkg::CART_AW:0]    rom_len
);

	logic [audio_pkg::SAMPLE_W-1:0] mem [audio_pkg::CART_BYTES];
	logic                           is_bin;
	logic                           wr_en;
	logic                           dl_d;

	assign is_bin = ioctl_index == io_pkg::BIN_INDEX;
	assign wr_en  = ioctl_wr && ioctl_download && is_bin;

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[ioctl_addr[audio_pkg::CART_AW-1:0]] <= ioctl_dout;
		rom_do <= mem[rom_addr];
	end

	// image length, last address written plus one.
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_d    <= 1'b0;
			rom_len <= '0;
		end else begin
			dl_d <= ioctl_download;
			if (ioctl_download && !dl_d && is_bin)
				rom_len <= '0;
			else if (wr_en)
				rom_len <= {1'b0, ioctl_addr[audio_pkg::CART_AW-1:0]} + 1'b1;
		end
	end

	wr_in_range: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		wr_en |-> ioctl_addr < io_pkg::IOCTL_AW'(audio_pkg::CART_BYTES)
	);

endmodule

`default_nettype wire

// ==== src/spi_download.sv ====
`default_nettype none

module spi_download (
	input  wire                           clk_sys,
	input  wire                           arst_n,
	input  wire                           SPI_SCK,
	input  wire                           SPI_SS2,
	input  wire                           SPI_DI,
	output logic                          ioctl_download,
	output logic [7:0]                    ioctl_index,
	output logic                          ioctl_wr,
	output logic [io_pkg::IOCTL_AW-1:0]   ioctl_addr,
	output logic [7:0]                    ioctl_dout
);

	logic [2:0] sck_s;
	logic [1:0] ss_s;
	logic [1:0] di_s;
	logic       sck_rise;
	logic       frame_off;

	logic [2:0] bit_cnt;
	logic [6:0] sr;
	logic [7:0] rx_byte;
	logic       first;
	logic [7:0] cmd;

	// two-flop synchronizers, one extra stage on SCK for the edge.
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sck_s <= '0;
			ss_s  <= '1;
			di_s  <= '0;
		end else begin
			sck_s <= {sck_s[1:0], SPI_SCK};
			ss_s  <= {ss_s[0], SPI_SS2};
			di_s  <= {di_s[0], SPI_DI};
		end
	end

	assign sck_rise  = sck_s[1] && !sck_s[2];
	assign frame_off = ss_s[1];
	assign rx_byte   = {sr, di_s[1]};

	// bit shifter, msb first.
	always_ff @(posedge clk_sys) begin
		if (sck_rise && !frame_off)
			sr <= {sr[5:0], di_s[1]};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
			first   <= 1'b1;
		end else if (frame_off) begin
			bit_cnt <= '0;
			first   <= 1'b1;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7)
				first <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd            <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			// address moves on after each write.
			if (ioctl_wr)
				ioctl_addr <= ioctl_addr + 1'b1;
			if (sck_rise && !frame_off && bit_cnt == 3'd7) begin
				if (first) begin
					cmd <= rx_byte;
				end else begin
					case (cmd)
						io_pkg::UIO_FILE_TX: begin
							if (rx_byte != 8'd0) begin
								ioctl_download <= 1'b1;
								ioctl_addr     <= '0;
							end else begin
								ioctl_download <= 1'b0;
							end
						end
						io_pkg::UIO_FILE_TX_DAT: begin
							if (ioctl_download)
								ioctl_wr <= 1'b1;
						end
						io_pkg::UIO_FILE_INDEX: ioctl_index <= rx_byte;
						default: ;
					endcase
				end
			end
		end
	end

	// data byte, held until the next one.
	always_ff @(posedge clk_sys) begin
		if (sck_rise && !frame_off && bit_cnt == 3'd7 && !first &&
				cmd == io_pkg::UIO_FILE_TX_DAT)
			ioctl_dout <= rx_byte;
	end

	wr_in_download: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |-> ioctl_download
	);

	// address only moves by one per write, except at a new start.
	addr_step: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		!$rose(ioctl_download) |->
			ioctl_addr == $past(ioctl_addr) + io_pkg::IOCTL_AW'($past(ioctl_wr))
	);

endmodule

`default_nettype wire

// ==== src/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	localparam int SAMPLE_W = 8;

	// cartridge RAM, 4096 bytes.
	localparam int CART_AW    = 12;
	localparam int CART_BYTES = 1 << CART_AW;

	// clocks per sample and the divider built from it.
	localparam int SAMPLE_DIV = 256;
	localparam int DIV_W      = $clog2(SAMPLE_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);

	// end of download to first counted DAC output.
	localparam int DAC_LAT = 4;

endpackage

`default_nettype wire

// ==== src/io_pkg.sv ====
`default_nettype none

package io_pkg;

	// file-transfer commands from the host.
	localparam logic [7:0] UIO_FILE_TX     = 8'h53;
	localparam logic [7:0] UIO_FILE_TX_DAT = 8'h54;
	localparam logic [7:0] UIO_FILE_INDEX  = 8'h55;

	// download address width.
	localparam int IOCTL_AW = 25;

	// index of the cartridge image.
	localparam logic [7:0] BIN_INDEX = 8'd0;

endpackage

`default_nettype wire
